// File: issue_pkg.sv
// Shared constants and enums for the out-of-order issue subsystem
// Pipe count, sequence number width, multiply latency, op and pipe state encodings

package issue_pkg;

  // --------------------
  // Sizing
  // --------------------

  // Identical execute pipes behind decode-issue
  localparam int NUM_PIPES = 3;

  // Width of the instruction sequence number
  localparam int SEQ_BITS = 5;

  // Cycles from dispatch to done for MUL
  localparam int MUL_LATENCY = 3;

  // --------------------
  // Encodings
  // --------------------

  // Operations handled by the execute pipes
  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_ADDI = 2'd1,
    OP_MUL  = 2'd2
  } issue_op_e;

  // Execute pipe FSM states
  typedef enum logic [1:0] {
    PIPE_IDLE = 2'd0,
    PIPE_BUSY = 2'd1,
    PIPE_DONE = 2'd2
  } pipe_state_e;

endpackage

// File: decode_issue.sv
`timescale 1ns/1ps
// Decode-issue stage for ADD, ADDI and MUL
// Reads a 32-entry register file, keeps a scoreboard of pending writes,
// stalls on RAW and WAW hazards and dispatches to the lowest free pipe

module decode_issue import issue_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,

  // Instruction stream
  input  logic                 in_val,
  output logic                 in_rdy,
  input  logic [31:0]          in_inst,
  input  logic [SEQ_BITS-1:0]  in_seq_num,

  // Dispatch to the execute pipes
  input  logic [NUM_PIPES-1:0] pipe_busy,
  output logic [NUM_PIPES-1:0] disp_val,
  output issue_op_e            disp_op,
  output logic [31:0]          disp_op1,
  output logic [31:0]          disp_op2,
  output logic [4:0]           disp_waddr,
  output logic [SEQ_BITS-1:0]  disp_seq_num,

  // Writeback from the completion arbiter
  input  logic                 wb_en,
  input  logic [4:0]           wb_waddr,
  input  logic [31:0]          wb_wdata
);

  // RV32 fields recognised by the decoder
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [2:0] F3_ADD     = 3'b000;
  localparam logic [6:0] F7_MULDIV  = 7'b0000001;

  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [4:0]           rs1;
  logic [4:0]           rs2;
  logic [4:0]           rd;
  logic [31:0]          imm_i;
  issue_op_e            op;
  logic                 uses_rs2;

  logic [31:0]          regs [32];
  logic [31:0]          pending;

  logic                 raw_stall;
  logic                 waw_stall;
  logic [NUM_PIPES-1:0] free_onehot;
  logic                 any_free;
  logic                 in_fire;

  // --------------------
  // Decode
  // --------------------

  assign opcode = in_inst[6:0];
  assign funct3 = in_inst[14:12];
  assign funct7 = in_inst[31:25];
  assign rs1    = in_inst[19:15];
  assign rs2    = in_inst[24:20];
  assign rd     = in_inst[11:7];

  // Sign-extended I-type immediate
  assign imm_i  = {{20{in_inst[31]}}, in_inst[31:20]};

  always_comb begin
    op       = OP_ADD;
    uses_rs2 = 1'b1;
    case (opcode)
      OPC_OP_IMM: begin
        if (funct3 == F3_ADD) begin
          op       = OP_ADDI;
          uses_rs2 = 1'b0;
        end
      end
      OPC_OP: begin
        if (funct3 == F3_ADD && funct7 == F7_MULDIV) begin
          op = OP_MUL;
        end
      end
      default: begin
        op = OP_ADD;
      end
    endcase
  end

  // --------------------
  // Hazards and pipe select
  // --------------------

  // A source waits until its writeback has landed since there is no bypass
  assign raw_stall = pending[rs1] | (uses_rs2 & pending[rs2]);
  assign waw_stall = pending[rd];

  // Lowest clear bit of the busy vector
  assign free_onehot = ~pipe_busy & (pipe_busy + 1'b1);
  assign any_free    = |free_onehot;

  assign in_rdy  = ~rst & ~raw_stall & ~waw_stall & any_free;
  assign in_fire = in_val & in_rdy;

  // --------------------
  // Dispatch
  // --------------------

  assign disp_val     = in_fire ? free_onehot : '0;
  assign disp_op      = op;
  assign disp_op1     = regs[rs1];
  assign disp_op2     = uses_rs2 ? regs[rs2] : imm_i;
  assign disp_waddr   = rd;
  assign disp_seq_num = in_seq_num;

  // --------------------
  // Register file and scoreboard
  // --------------------

  // x0 is never written so it reads as zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else if (wb_en && wb_waddr != 5'd0) begin
      regs[wb_waddr] <= wb_wdata;
    end
  end

  // Writeback and a new claim never hit the same register in one cycle,
  // since a pending destination blocks acceptance
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (wb_en) begin
        pending[wb_waddr] <= 1'b0;
      end
      if (in_fire && rd != 5'd0) begin
        pending[rd] <= 1'b1;
      end
    end
  end

endmodule

// File: exec_pipe.sv
`timescale 1ns/1ps
// Execute pipe for ADD, ADDI and MUL
// Captures operands on dispatch, waits out the op latency, then holds
// the result until the completion arbiter grants it

module exec_pipe import issue_pkg::*; (
  input  logic                clk,
  input  logic                rst,

  input  logic                disp_val,
  input  issue_op_e           disp_op,
  input  logic [31:0]         disp_op1,
  input  logic [31:0]         disp_op2,
  input  logic [4:0]          disp_waddr,
  input  logic [SEQ_BITS-1:0] disp_seq_num,
  output logic                pipe_busy,

  output logic                done_val,
  output logic [4:0]          done_waddr,
  output logic [31:0]         done_wdata,
  output logic [SEQ_BITS-1:0] done_seq_num,
  input  logic                done_grant
);

  pipe_state_e                    state;
  logic [$clog2(MUL_LATENCY)-1:0] count;
  issue_op_e                      op;
  logic [31:0]                    op1;
  logic [31:0]                    op2;

  // Add-type goes straight to done while MUL sits in busy first
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= PIPE_IDLE;
      count <= '0;
    end else begin
      case (state)
        PIPE_IDLE: begin
          if (disp_val) begin
            if (disp_op == OP_MUL) begin
              state <= PIPE_BUSY;
              count <= $bits(count)'(MUL_LATENCY - 2);
            end else begin
              state <= PIPE_DONE;
            end
          end
        end
        PIPE_BUSY: begin
          if (count == '0) begin
            state <= PIPE_DONE;
          end else begin
            count <= count - 1'b1;
          end
        end
        PIPE_DONE: begin
          if (done_grant) begin
            state <= PIPE_IDLE;
          end
        end
        default: begin
          state <= PIPE_IDLE;
        end
      endcase
    end
  end

  // Operand capture
  always_ff @(posedge clk) begin
    if (disp_val && state == PIPE_IDLE) begin
      op           <= disp_op;
      op1          <= disp_op1;
      op2          <= disp_op2;
      done_waddr   <= disp_waddr;
      done_seq_num <= disp_seq_num;
    end
  end

  // Low 32 bits of the product, or the 32-bit sum
  always_comb begin
    if (op == OP_MUL) begin
      done_wdata = op1 * op2;
    end else begin
      done_wdata = op1 + op2;
    end
  end

  assign pipe_busy = (state != PIPE_IDLE);
  assign done_val  = (state == PIPE_DONE);

endmodule

// File: complete_arbiter.sv
`timescale 1ns/1ps
// Completion arbiter
// Selects the lowest-numbered done pipe, drives the output stream
// and grants and writes back on the fire cycle

module complete_arbiter import issue_pkg::*; (
  input  logic [NUM_PIPES-1:0] done_val,
  input  logic [4:0]           done_waddr   [NUM_PIPES],
  input  logic [31:0]          done_wdata   [NUM_PIPES],
  input  logic [SEQ_BITS-1:0]  done_seq_num [NUM_PIPES],
  output logic [NUM_PIPES-1:0] done_grant,

  // Output stream
  output logic                 out_val,
  input  logic                 out_rdy,
  output logic [4:0]           out_waddr,
  output logic [31:0]          out_wdata,
  output logic [SEQ_BITS-1:0]  out_seq_num,

  // Writeback to decode-issue
  output logic                 wb_en,
  output logic [4:0]           wb_waddr,
  output logic [31:0]          wb_wdata
);

  logic [NUM_PIPES-1:0] sel_onehot;
  logic                 out_fire;

  // Lowest set bit of the done vector
  assign sel_onehot = done_val & ~(done_val - 1'b1);

  // --------------------
  // Result mux
  // --------------------

  always_comb begin
    out_waddr   = '0;
    out_wdata   = '0;
    out_seq_num = '0;
    for (int i = 0; i < NUM_PIPES; i++) begin
      if (sel_onehot[i]) begin
        out_waddr   = done_waddr[i];
        out_wdata   = done_wdata[i];
        out_seq_num = done_seq_num[i];
      end
    end
  end

  assign out_val  = |done_val;
  assign out_fire = out_val & out_rdy;

  // Grant and writeback only when the output stream takes the result
  assign done_grant = {NUM_PIPES{out_fire}} & sel_onehot;
  assign wb_en      = out_fire;
  assign wb_waddr   = out_waddr;
  assign wb_wdata   = out_wdata;

endmodule

// File: issue_core.sv
`timescale 1ns/1ps
// Top of the issue subsystem
// Decode-issue feeding a bank of identical execute pipes, drained by
// the completion arbiter that also writes back the register file

module issue_core import issue_pkg::*; (
  input  logic                clk,
  input  logic                rst,

  input  logic                in_val,
  output logic                in_rdy,
  input  logic [31:0]         in_inst,
  input  logic [SEQ_BITS-1:0] in_seq_num,

  output logic                out_val,
  input  logic                out_rdy,
  output logic [4:0]          out_waddr,
  output logic [31:0]         out_wdata,
  output logic [SEQ_BITS-1:0] out_seq_num
);

  // Dispatch bus with shared data and a strobe per pipe
  wire [NUM_PIPES-1:0] disp_val;
  wire [NUM_PIPES-1:0] pipe_busy;
  issue_op_e           disp_op;
  logic [31:0]         disp_op1;
  logic [31:0]         disp_op2;
  logic [4:0]          disp_waddr;
  logic [SEQ_BITS-1:0] disp_seq_num;

  // Done signals with one entry per pipe
  wire [NUM_PIPES-1:0] done_val;
  wire [NUM_PIPES-1:0] done_grant;
  wire [4:0]           done_waddr   [NUM_PIPES];
  wire [31:0]          done_wdata   [NUM_PIPES];
  wire [SEQ_BITS-1:0]  done_seq_num [NUM_PIPES];

  logic                wb_en;
  logic [4:0]          wb_waddr;
  logic [31:0]         wb_wdata;

  decode_issue u_decode_issue (
    .clk          (clk),
    .rst          (rst),
    .in_val       (in_val),
    .in_rdy       (in_rdy),
    .in_inst      (in_inst),
    .in_seq_num   (in_seq_num),
    .pipe_busy    (pipe_busy),
    .disp_val     (disp_val),
    .disp_op      (disp_op),
    .disp_op1     (disp_op1),
    .disp_op2     (disp_op2),
    .disp_waddr   (disp_waddr),
    .disp_seq_num (disp_seq_num),
    .wb_en        (wb_en),
    .wb_waddr     (wb_waddr),
    .wb_wdata     (wb_wdata)
  );

  // --------------------
  // Execute pipes
  // --------------------

  for (genvar i = 0; i < NUM_PIPES; i++) begin : g_pipe
    exec_pipe u_exec_pipe (
      .clk          (clk),
      .rst          (rst),
      .disp_val     (disp_val[i]),
      .disp_op      (disp_op),
      .disp_op1     (disp_op1),
      .disp_op2     (disp_op2),
      .disp_waddr   (disp_waddr),
      .disp_seq_num (disp_seq_num),
      .pipe_busy    (pipe_busy[i]),
      .done_val     (done_val[i]),
      .done_waddr   (done_waddr[i]),
      .done_wdata   (done_wdata[i]),
      .done_seq_num (done_seq_num[i]),
      .done_grant   (done_grant[i])
    );
  end

  complete_arbiter u_complete_arbiter (
    .done_val     (done_val),
    .done_waddr   (done_waddr),
    .done_wdata   (done_wdata),
    .done_seq_num (done_seq_num),
    .done_grant   (done_grant),
    .out_val      (out_val),
    .out_rdy      (out_rdy),
    .out_waddr    (out_waddr),
    .out_wdata    (out_wdata),
    .out_seq_num  (out_seq_num),
    .wb_en        (wb_en),
    .wb_waddr     (wb_waddr),
    .wb_wdata     (wb_wdata)
  );

endmodule

// File: issue_checker.sv
`timescale 1ns/1ps
// Completion checker for the issue subsystem
// Matches each completion to its trace entry by sequence number and
// checks destination, data, write order per register and stall behavior

module issue_checker import issue_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_val,
  input  logic                in_rdy,
  input  logic [SEQ_BITS-1:0] in_seq_num,
  input  logic                out_val,
  input  logic                out_rdy,
  input  logic [4:0]          out_waddr,
  input  logic [31:0]         out_wdata,
  input  logic [SEQ_BITS-1:0] out_seq_num,
  output logic                all_done,
  output int                  error_count,
  output int                  done_count
);

  localparam int MAX_LINES = 32;

  logic [31:0]          trace_mem [5*MAX_LINES];
  int                   num_lines;
  logic [MAX_LINES-1:0] accepted;
  logic [MAX_LINES-1:0] completed;
  int                   last_idx  [32];
  int                   test_left [16];
  int                   test_err  [16];
  int                   acc_idx;
  logic                 held = 1'b0;
  logic [SEQ_BITS-1:0]  held_seq;
  logic [4:0]           held_waddr;
  logic [31:0]          held_wdata;

  initial begin
    error_count = 0;
    done_count  = 0;
    accepted    = '0;
    completed   = '0;
    for (int r = 0; r < 32; r++) begin
      last_idx[r] = -1;
    end
    for (int t = 0; t < 16; t++) begin
      test_left[t] = 0;
      test_err[t]  = 0;
    end
    $readmemh("issue_trace.txt", trace_mem);
    num_lines = 0;
    while (num_lines < MAX_LINES && !$isunknown(trace_mem[5*num_lines])) begin
      test_left[trace_mem[5*num_lines][3:0]]++;
      num_lines++;
    end
  end

  assign all_done = (num_lines > 0) && (done_count == num_lines);

  // First entry with this sequence number in the wanted state
  function automatic int find_entry(input logic [SEQ_BITS-1:0] seq, input logic want_acc);
    for (int i = 0; i < num_lines; i++) begin
      if (trace_mem[5*i+2][SEQ_BITS-1:0] == seq && accepted[i] == want_acc && !completed[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  // --------------------
  // Completion compare
  // --------------------
  task automatic check_completion();
    int idx;
    int tid;
    int dest;
    idx = find_entry(out_seq_num, 1'b1);
    if (idx < 0) begin
      $display("at %0t a completion arrived for seq %0d, which is not outstanding",
               $time, out_seq_num);
      error_count++;
    end else begin
      tid  = trace_mem[5*idx][3:0];
      dest = trace_mem[5*idx+3][4:0];
      if (out_waddr != dest[4:0]) begin
        $display("mismatch at %0t: seq %0d wrote x%0d, expected x%0d",
                 $time, out_seq_num, out_waddr, dest);
        error_count++;
        test_err[tid]++;
      end
      if (out_wdata != trace_mem[5*idx+4]) begin
        $display("mismatch at %0t: seq %0d data %08h, expected %08h",
                 $time, out_seq_num, out_wdata, trace_mem[5*idx+4]);
        error_count++;
        test_err[tid]++;
      end
      // Writes to one register must land in program order
      if (last_idx[dest] > idx) begin
        $display("at %0t seq %0d completed after a younger write to x%0d",
                 $time, out_seq_num, dest);
        error_count++;
        test_err[tid]++;
      end
      last_idx[dest] = idx;
      completed[idx] = 1'b1;
      done_count++;
      test_left[tid]--;
      if (test_left[tid] == 0) begin
        $display("test %0d done with %0d errors", tid, test_err[tid]);
      end
    end
  endtask

  task print_summary();
    $display("summary: %0d of %0d instructions completed, %0d errors",
             done_count, num_lines, error_count);
  endtask

  // Ports are stable at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      // A lower pipe may take over the output, but a stalled result
      // never vanishes and never changes under its own sequence number
      if (held && !out_val) begin
        $display("at %0t a result waiting on out_rdy was dropped", $time);
        error_count++;
      end else if (held && out_seq_num == held_seq &&
                   (out_waddr != held_waddr || out_wdata != held_wdata)) begin
        $display("mismatch at %0t: stalled result for seq %0d changed", $time, held_seq);
        error_count++;
      end
      if (out_val && out_rdy) begin
        check_completion();
      end
      if (in_val && in_rdy) begin
        acc_idx = find_entry(in_seq_num, 1'b0);
        if (acc_idx < 0) begin
          $display("at %0t seq %0d was accepted but is not in the trace", $time, in_seq_num);
          error_count++;
        end else begin
          accepted[acc_idx] = 1'b1;
        end
      end
      held       = out_val && !out_rdy;
      held_seq   = out_seq_num;
      held_waddr = out_waddr;
      held_wdata = out_wdata;
    end
  end

endmodule

// File: tb_issue_core.sv
`timescale 1ns/1ps
// Testbench for the issue subsystem
// Replays the instruction trace with random input gaps and random
// output stalls while the checker compares every completion

module tb_issue_core import issue_pkg::*; ();

  localparam int MAX_LINES = 32;

  logic                clk = 1'b0;
  logic                rst;
  logic                in_val;
  logic                in_rdy;
  logic [31:0]         in_inst;
  logic [SEQ_BITS-1:0] in_seq_num;
  logic                out_val;
  logic                out_rdy;
  logic [4:0]          out_waddr;
  logic [31:0]         out_wdata;
  logic [SEQ_BITS-1:0] out_seq_num;

  logic                all_done;
  int                  error_count;
  int                  done_count;

  logic [31:0]         trace_mem [5*MAX_LINES];
  int                  num_lines;
  int                  line_idx;
  int                  gap;
  int                  cycle_count = 0;
  int                  cycle_limit;
  logic                in_taken = 1'b0;
  logic                timed_out;
  integer              seed;
  logic [31:0]         rnd;

  issue_core u_issue_core (
    .clk         (clk),
    .rst         (rst),
    .in_val      (in_val),
    .in_rdy      (in_rdy),
    .in_inst     (in_inst),
    .in_seq_num  (in_seq_num),
    .out_val     (out_val),
    .out_rdy     (out_rdy),
    .out_waddr   (out_waddr),
    .out_wdata   (out_wdata),
    .out_seq_num (out_seq_num)
  );

  issue_checker u_issue_checker (
    .clk         (clk),
    .rst         (rst),
    .in_val      (in_val),
    .in_rdy      (in_rdy),
    .in_seq_num  (in_seq_num),
    .out_val     (out_val),
    .out_rdy     (out_rdy),
    .out_waddr   (out_waddr),
    .out_wdata   (out_wdata),
    .out_seq_num (out_seq_num),
    .all_done    (all_done),
    .error_count (error_count),
    .done_count  (done_count)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // Acceptance sampled mid-cycle and acted on after the next edge
  always @(negedge clk) begin
    in_taken <= in_val & in_rdy;
  end

  task automatic present_instruction(input int idx);
    in_val     = 1'b1;
    in_inst    = trace_mem[5*idx+1];
    in_seq_num = trace_mem[5*idx+2][SEQ_BITS-1:0];
  endtask

  initial begin
    rst        = 1'b1;
    in_val     = 1'b0;
    in_inst    = '0;
    in_seq_num = '0;
    out_rdy    = 1'b0;
    seed       = 32'h9f8a;
    line_idx   = 0;
    gap        = 0;
    $readmemh("issue_trace.txt", trace_mem);
    num_lines = 0;
    while (num_lines < MAX_LINES && !$isunknown(trace_mem[5*num_lines])) begin
      num_lines++;
    end
    cycle_limit = 20 * num_lines + 100;

    repeat (16) @(posedge clk);
    #0.5;
    rst = 1'b0;

    // --------------------
    // Stimulus loop
    // --------------------
    while (!all_done && cycle_count < cycle_limit) begin
      @(posedge clk);
      #0.5;
      rnd     = $random(seed);
      out_rdy = (rnd[1:0] != 2'b00);
      if (in_taken) begin
        in_val   = 1'b0;
        line_idx = line_idx + 1;
        gap      = (rnd[3:2] == 2'b00) ? int'(rnd[5:4]) : 0;
      end
      if (!in_val && line_idx < num_lines) begin
        if (gap > 0) begin
          gap = gap - 1;
        end else begin
          present_instruction(line_idx);
        end
      end
    end
    timed_out = !all_done;

    // Idle a few cycles so that any extra completion shows up as an error
    if (!timed_out) begin
      @(posedge clk);
      #0.5;
      in_val  = 1'b0;
      out_rdy = 1'b1;
      repeat (10) @(posedge clk);
    end

    u_issue_checker.print_summary();
    if (timed_out) begin
      $display("run timed out after %0d cycles with %0d of %0d completions missing",
               cycle_count, num_lines - done_count, num_lines);
    end
    if (!timed_out && error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: issue_trace.txt
// test id, instruction word, sequence number, expected destination, expected write data
// tests: 1 add/addi, 2 mul, 3 raw chain, 4 waw, 5 mixed under back-pressure
1 00500093 00 01 00000005 // addi x1, x0, 5
1 ffd00113 01 02 fffffffd // addi x2, x0, -3
1 002081b3 02 03 00000002 // add  x3, x1, x2
1 06408013 03 00 00000069 // addi x0, x1, 100
1 7ff00213 04 04 000007ff // addi x4, x0, 2047
1 004202b3 05 05 00000ffe // add  x5, x4, x4
2 00c00313 06 06 0000000c // addi x6, x0, 12
2 ff900393 07 07 fffffff9 // addi x7, x0, -7
2 02730433 08 08 ffffffac // mul  x8, x6, x7
2 004084b3 09 09 00000804 // add  x9, x1, x4
2 02420533 0a 0a 003ff001 // mul  x10, x4, x4
2 02a50633 0b 0c 017fe001 // mul  x12, x10, x10
2 00100593 0c 0b 00000001 // addi x11, x0, 1
3 00300693 0d 0d 00000003 // addi x13, x0, 3
3 00d68733 0e 0e 00000006 // add  x14, x13, x13
3 02d707b3 0f 0f 00000012 // mul  x15, x14, x13
3 fec78813 10 10 fffffffe // addi x16, x15, -20
3 02f808b3 11 11 ffffffdc // mul  x17, x16, x15
3 00e88933 12 12 ffffffe2 // add  x18, x17, x14
4 02630a33 13 14 00000090 // mul  x20, x6, x6
4 00900a13 14 14 00000009 // addi x20, x0, 9
4 001a0a33 15 14 0000000e // add  x20, x20, x1
4 02738ab3 16 15 00000031 // mul  x21, x7, x7
4 001a8a93 17 15 00000032 // addi x21, x21, 1
5 02710b33 18 16 00000015 // mul  x22, x2, x7
5 fff00b93 19 17 ffffffff // addi x23, x0, -1
5 017b8c33 1a 18 fffffffe // add  x24, x23, x23
5 024b8cb3 1b 19 fffff801 // mul  x25, x23, x4
5 019b0d33 1c 1a fffff816 // add  x26, x22, x25

// File: vlog.f
issue_pkg.sv
decode_issue.sv
exec_pipe.sv
complete_arbiter.sv
issue_core.sv
issue_checker.sv
tb_issue_core.sv
